//--- Emulator.f
src/DekatronPkg.sv
src/PanelPkg.sv
src/DekatronCounter.sv
src/DekatronPC.sv
src/KeyboardScanner.sv
src/ApbRegisterBlock.sv
src/Emulator.sv
bench/ClockGen.sv
bench/EmulatorTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP := EmulatorTb
FILELIST := Emulator.f
BUILD_DIR := obj_dir

SOURCES := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/ClockGen.sv
`timescale 1ns/1ps

module ClockGen #(
    parameter int HalfPeriod = 20,
    parameter int ResetCycles = 4
) (
    output logic Clk,
    output logic reset
);
    initial begin
        Clk = 1'b0;
        forever #(HalfPeriod) Clk = ~Clk;
    end

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        reset <= 1'b0; // power-on reset.
    end

endmodule

//--- bench/EmulatorTb.sv
`timescale 1ns/1ps

module EmulatorTb;
    localparam int ScanDivisor = 4;
    localparam int ClockPeriod = 40;
    localparam int ShortRunLimit = 100;
    localparam int CountRunLimit = 400;
    localparam int LongRunLimit = 8000;
    localparam int KeySettle = 8 * ScanDivisor + 2; // one full column sweep plus the pulse.
    // count, wrap, cells, loops, step and protection, keypad.
    localparam int TestCycles = 1200 + 200 + 400 + 500 + (2 * LongRunLimit + 600) + 700;
    localparam int WatchdogCycles = TestCycles + 1000;

    logic Clk;
    logic powerOnReset;
    logic benchReset;
    logic reset;
    logic [PanelPkg::KeyRows-1:0] keyRows;
    logic [2:0] keyColumn;
    logic Cout;
    DekatronPkg::dpcState DPC_currentState;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [PanelPkg::KeyCount-1:0] pressedKeys;
    DekatronPkg::insnOpcode insnList[$];
    int coutCount = 0;

    assign reset = powerOnReset || benchReset;
    assign keyRows = pressedKeys[keyColumn*PanelPkg::KeyRows +: PanelPkg::KeyRows]; // key matrix.

    ClockGen #(.HalfPeriod(ClockPeriod / 2), .ResetCycles(4)) clockGen (
        .Clk(Clk), .reset(powerOnReset)
    );

    Emulator #(
        .IpDigits(2), .ApDigits(2), .DataDigits(3), .LoopDigits(2), .ScanDivisor(ScanDivisor)
    ) UUT (
        .Clk(Clk), .reset(reset), .keyRows(keyRows), .keyColumn(keyColumn), .Cout(Cout),
        .DPC_currentState(DPC_currentState), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always @(posedge Clk) begin
        if (Cout) coutCount <= coutCount + 1; // sticky record of carry pulses.
    end

    function automatic logic [31:0] toBcd(input int value);
        logic [31:0] result;
        int rest;
        result = '0;
        rest = value;
        for (int i = 0; i < 8; i++) begin
            result[i*4 +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return result;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string message);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, message, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] value, output logic err);
        @(posedge Clk);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= value;
        @(posedge Clk);
        penable <= 1'b1;
        @(negedge Clk);
        checkValue(32'(pready), 32'h1, "pready in a write access");
        err = pslverr;
        @(posedge Clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] value);
        @(posedge Clk);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge Clk);
        penable <= 1'b1;
        @(negedge Clk);
        checkValue(32'(pready), 32'h1, "pready in a read access");
        value = prdata;
        @(posedge Clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expectRegister(input logic [11:0] addr, input logic [31:0] expected,
                                  input string message);
        logic [31:0] value;
        apbRead(addr, value);
        checkValue(value, expected, message);
    endtask

    task automatic sendCommand(input logic [31:0] command);
        logic err;
        apbWrite(PanelPkg::RegControl, command, err);
        checkValue(32'(err), 32'h0, "pslverr on a control write");
    endtask

    task automatic restart();
        @(posedge Clk);
        benchReset <= 1'b1;
        repeat (4) @(posedge Clk);
        benchReset <= 1'b0;
    endtask

    task automatic addInsn(input DekatronPkg::insnOpcode op, input int count);
        for (int i = 0; i < count; i++) insnList.push_back(op);
    endtask

    // memory is addressed by the BCD value of the instruction index.
    task automatic loadProgram(input int base);
        logic err;
        for (int i = 0; i < insnList.size(); i++) begin
            apbWrite(PanelPkg::ProgramBase + 12'(toBcd(base + i) << 2), 32'(insnList[i]), err);
            checkValue(32'(err), 32'h0, "pslverr on a halted program write");
        end
        insnList.delete();
    endtask

    task automatic waitHalted(input int limit);
        logic [31:0] status;
        int cycles;
        cycles = 0;
        status = 32'hffff_ffff;
        while (status != 32'(DekatronPkg::stHalted)) begin
            if (cycles >= limit) begin
                $display("machine did not return to the halted state within %0d cycles", limit);
                $display("Finished with errors");
                $fatal(1);
            end
            apbRead(PanelPkg::RegStatus, status);
            cycles += 3;
        end
        checkValue(32'(DPC_currentState), 32'(DekatronPkg::stHalted), "state output when halted");
    endtask

    task automatic holdKeys(input logic [PanelPkg::KeyCount-1:0] mask);
        @(posedge Clk);
        pressedKeys <= mask;
        repeat (KeySettle) @(posedge Clk);
    endtask

    task automatic countFromReset();
        int count;
        count = 1 + int'($urandom % 98); // halt must still fit in two IP digits.
        checkValue(32'(keyColumn), 32'h0, "keyColumn after reset");
        expectRegister(PanelPkg::RegStatus, 32'(DekatronPkg::stHalted), "state after reset");
        expectRegister(PanelPkg::RegIp, 32'h0, "IP after reset");
        expectRegister(PanelPkg::RegAp, 32'h0, "AP after reset");
        expectRegister(PanelPkg::RegData, 32'h0, "data after reset");
        expectRegister(PanelPkg::RegLoop, 32'h0, "loop count after reset");
        checkValue(32'(Cout), 32'h0, "Cout after reset");
        addInsn(DekatronPkg::opInc, count);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        sendCommand(32'h1);
        waitHalted(CountRunLimit);
        expectRegister(PanelPkg::RegData, toBcd(count), "data after the increments");
        expectRegister(PanelPkg::RegIp, toBcd(count), "IP on the halt");
    endtask

    task automatic wrapBelowZero();
        int coutBefore;
        restart();
        addInsn(DekatronPkg::opDec, 1);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        coutBefore = coutCount;
        sendCommand(32'h1);
        waitHalted(ShortRunLimit);
        expectRegister(PanelPkg::RegData, 32'h999, "data after a decrement from zero");
        checkValue(32'(coutCount > coutBefore), 32'h1, "Cout pulse on the wrap");
    endtask

    task automatic moveBetweenCells();
        restart();
        addInsn(DekatronPkg::opInc, 3);
        addInsn(DekatronPkg::opNext, 1);
        addInsn(DekatronPkg::opInc, 5);
        addInsn(DekatronPkg::opPrev, 1);
        addInsn(DekatronPkg::opDec, 1);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        sendCommand(32'h1);
        waitHalted(ShortRunLimit);
        expectRegister(PanelPkg::RegData, 32'h2, "cell 0 after the pointer moves");
        expectRegister(PanelPkg::RegAp, 32'h0, "AP back on cell 0");
        addInsn(DekatronPkg::opNext, 1); // continues from the halt at index 11.
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(11);
        sendCommand(32'h1);
        waitHalted(ShortRunLimit);
        expectRegister(PanelPkg::RegData, 32'h5, "cell 1 kept its value");
        expectRegister(PanelPkg::RegAp, 32'h1, "AP on cell 1");
    endtask

    task automatic runLoops();
        restart();
        addInsn(DekatronPkg::opInc, 3);
        addInsn(DekatronPkg::opLoopStart, 1);
        addInsn(DekatronPkg::opDec, 1);
        addInsn(DekatronPkg::opNext, 1);
        addInsn(DekatronPkg::opInc, 2);
        addInsn(DekatronPkg::opPrev, 1);
        addInsn(DekatronPkg::opLoopEnd, 1);
        addInsn(DekatronPkg::opNext, 1);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        sendCommand(32'h1);
        waitHalted(CountRunLimit);
        expectRegister(PanelPkg::RegData, 32'h6, "cell 1 after the countdown loop");
        expectRegister(PanelPkg::RegAp, 32'h1, "AP after the countdown loop");
        expectRegister(PanelPkg::RegIp, 32'h11, "IP after the countdown loop");
        restart();
        addInsn(DekatronPkg::opLoopStart, 1); // [+[+]+] skipped on a zero cell.
        addInsn(DekatronPkg::opInc, 1);
        addInsn(DekatronPkg::opLoopStart, 1);
        addInsn(DekatronPkg::opInc, 1);
        addInsn(DekatronPkg::opLoopEnd, 1);
        addInsn(DekatronPkg::opInc, 1);
        addInsn(DekatronPkg::opLoopEnd, 1);
        addInsn(DekatronPkg::opInc, 1);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        sendCommand(32'h1);
        waitHalted(ShortRunLimit);
        expectRegister(PanelPkg::RegData, 32'h1, "data after skipping the nested loop");
        expectRegister(PanelPkg::RegIp, 32'h8, "IP after skipping the nested loop");
        expectRegister(PanelPkg::RegLoop, 32'h0, "loop depth after the skip");
    endtask

    task automatic stepAndProtect();
        logic err;
        logic [31:0] value;
        restart();
        addInsn(DekatronPkg::opInc, 4);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        for (int i = 1; i <= 3; i++) begin
            sendCommand(32'h4);
            waitHalted(ShortRunLimit);
            expectRegister(PanelPkg::RegIp, toBcd(i), "IP after a step");
            expectRegister(PanelPkg::RegData, toBcd(i), "data after a step");
        end
        restart();
        addInsn(DekatronPkg::opDec, 1); // -[-] counts 999 down to zero.
        addInsn(DekatronPkg::opLoopStart, 1);
        addInsn(DekatronPkg::opDec, 1);
        addInsn(DekatronPkg::opLoopEnd, 1);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        sendCommand(32'h1);
        apbWrite(PanelPkg::ProgramBase + 12'h010, 32'(DekatronPkg::opNop), err);
        checkValue(32'(err), 32'h1, "pslverr on a program write during a run");
        sendCommand(32'h2);
        waitHalted(ShortRunLimit);
        apbRead(PanelPkg::RegIp, value);
        checkValue(32'(value < 32'h4), 32'h1, "host halt stopped inside the loop");
        sendCommand(32'h1);
        waitHalted(LongRunLimit);
        expectRegister(PanelPkg::RegIp, 32'h4, "halt instruction left in place");
        expectRegister(PanelPkg::RegData, 32'h0, "data after the countdown");
    endtask

    task automatic pressPanelKeys();
        restart();
        addInsn(DekatronPkg::opInc, 3);
        addInsn(DekatronPkg::opHalt, 1);
        loadProgram(0);
        holdKeys(40'(1) << PanelPkg::KeyHalt);
        expectRegister(PanelPkg::RegKeysLow, 32'h2, "Halt key in the key state");
        expectRegister(PanelPkg::RegStatus, 32'(DekatronPkg::stHalted), "state with Halt held");
        holdKeys('0);
        holdKeys(40'(1) << PanelPkg::KeyStep);
        expectRegister(PanelPkg::RegKeysLow, 32'h4, "Step key in the key state");
        waitHalted(ShortRunLimit);
        expectRegister(PanelPkg::RegIp, 32'h1, "IP after a Step key press");
        holdKeys('0);
        holdKeys(40'(1) << PanelPkg::KeyRun);
        expectRegister(PanelPkg::RegKeysLow, 32'h1, "Run key in the key state");
        waitHalted(ShortRunLimit);
        expectRegister(PanelPkg::RegIp, 32'h3, "IP after a Run key press");
        expectRegister(PanelPkg::RegData, 32'h3, "data after a Run key press");
        holdKeys('0);
        holdKeys(40'(1) << 37);
        expectRegister(PanelPkg::RegKeysHigh, 32'h20, "key 37 in the high key word");
        expectRegister(PanelPkg::RegKeysLow, 32'h0, "low key word with key 37 alone");
        expectRegister(PanelPkg::RegStatus, 32'(DekatronPkg::stHalted), "state with key 37");
        expectRegister(PanelPkg::RegIp, 32'h3, "IP with key 37");
        holdKeys('0);
    endtask

    initial begin
        void'($urandom(32'h1ec4));
        benchReset = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pressedKeys = '0;
        while (powerOnReset !== 1'b0) @(posedge Clk);
        countFromReset();
        wrapBelowZero();
        moveBetweenCells();
        runLoops();
        stepAndProtect();
        pressPanelKeys();
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("simulation timed out after %0d cycles", WatchdogCycles);
        $display("Finished with errors");
        $fatal(1);
    end

endmodule

//--- src/ApbRegisterBlock.sv
`timescale 1ns/1ps

module ApbRegisterBlock #(
    parameter int IpDigits = 2,
    parameter int ApDigits = 2,
    parameter int DataDigits = 3,
    parameter int LoopDigits = 2
) (
    input  logic Clk,
    input  logic reset,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    input  DekatronPkg::dpcState state,
    input  logic [IpDigits*DekatronPkg::DigitWidth-1:0] ipAddress,
    input  logic [ApDigits*DekatronPkg::DigitWidth-1:0] apAddress,
    input  logic [DataDigits*DekatronPkg::DigitWidth-1:0] data,
    input  logic [LoopDigits*DekatronPkg::DigitWidth-1:0] loopCount,
    input  logic [PanelPkg::KeyCount-1:0] keysCurrentState,
    output logic hostRun,
    output logic hostHalt,
    output logic hostStep,
    output logic progWrite,
    output logic [IpDigits*DekatronPkg::DigitWidth-1:0] progAddr,
    output logic [DekatronPkg::InsnWidth-1:0] progData
);
    localparam int IpWidth = IpDigits * DekatronPkg::DigitWidth;
    localparam int ProgramEnd = int'(PanelPkg::ProgramBase) + 4 * (1 << IpWidth);

    logic writeAccess;
    logic controlWrite;
    logic progHit;
    logic [11:0] progOffset;

    assign pready = 1'b1; // no wait states.
    assign writeAccess = psel && penable && pwrite;
    assign controlWrite = writeAccess && (paddr == PanelPkg::RegControl);
    assign progOffset = paddr - PanelPkg::ProgramBase;
    assign progHit = (int'(paddr) >= int'(PanelPkg::ProgramBase)) && (int'(paddr) < ProgramEnd);
    assign pslverr = writeAccess && progHit && (state != DekatronPkg::stHalted);

    always_ff @(posedge Clk) begin
        if (reset) begin
            hostRun <= 1'b0;
            hostHalt <= 1'b0;
            hostStep <= 1'b0;
            progWrite <= 1'b0;
        end else begin
            hostRun <= controlWrite && pwdata[0];
            hostHalt <= controlWrite && pwdata[1];
            hostStep <= controlWrite && pwdata[2];
            progWrite <= writeAccess && progHit && (state == DekatronPkg::stHalted);
        end
    end

    always_ff @(posedge Clk) begin
        if (writeAccess && progHit) begin
            progAddr <= IpWidth'(progOffset >> 2); // byte offset to word index.
            progData <= pwdata[DekatronPkg::InsnWidth-1:0];
        end
    end

    always_comb begin
        case (paddr)
            PanelPkg::RegStatus:   prdata = 32'(state);
            PanelPkg::RegIp:       prdata = 32'(ipAddress);
            PanelPkg::RegAp:       prdata = 32'(apAddress);
            PanelPkg::RegData:     prdata = 32'(data);
            PanelPkg::RegLoop:     prdata = 32'(loopCount);
            PanelPkg::RegKeysLow:  prdata = keysCurrentState[31:0];
            PanelPkg::RegKeysHigh: prdata = 32'(keysCurrentState[PanelPkg::KeyCount-1:32]);
            default:               prdata = '0;
        endcase
    end

endmodule

//--- src/DekatronCounter.sv
`timescale 1ns/1ps

module DekatronCounter #(
    parameter int Digits = 2
) (
    input  logic Clk,
    input  logic reset,
    input  logic clear,
    input  logic increment,
    input  logic decrement,
    input  logic load,
    input  logic [Digits*DekatronPkg::DigitWidth-1:0] loadValue,
    output logic [Digits*DekatronPkg::DigitWidth-1:0] value,
    output logic isZero,
    output logic wrap
);
    localparam int DigitBits = DekatronPkg::DigitWidth;

    logic [Digits*DigitBits-1:0] stepped;
    logic [Digits:0] carry;

    // each tube steps only when the tube below it rolls over.
    always_comb begin
        logic [DigitBits-1:0] digit;
        carry[0] = 1'b1;
        for (int i = 0; i < Digits; i++) begin
            digit = value[i*DigitBits +: DigitBits];
            if (!carry[i]) begin
                stepped[i*DigitBits +: DigitBits] = digit;
                carry[i+1] = 1'b0;
            end else if (increment) begin
                stepped[i*DigitBits +: DigitBits] = (digit == 4'd9) ? '0 : digit + 1'b1;
                carry[i+1] = (digit == 4'd9);
            end else begin
                stepped[i*DigitBits +: DigitBits] = (digit == '0) ? 4'd9 : digit - 1'b1;
                carry[i+1] = (digit == '0); // borrow.
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            value <= '0;
            wrap <= 1'b0;
        end else begin
            wrap <= 1'b0;
            if (clear) value <= '0;
            else if (load) value <= loadValue;
            else if (increment || decrement) begin
                value <= stepped;
                wrap <= carry[Digits]; // ran off the top tube.
            end
        end
    end

    assign isZero = (value == '0);

endmodule

//--- src/DekatronPC.sv
`timescale 1ns/1ps

module DekatronPC #(
    parameter int IpDigits = 2,
    parameter int ApDigits = 2,
    parameter int DataDigits = 3,
    parameter int LoopDigits = 2
) (
    input  logic Clk,
    input  logic reset,
    input  logic run,
    input  logic halt,
    input  logic step,
    input  logic progWrite,
    input  logic [IpDigits*DekatronPkg::DigitWidth-1:0] progAddr,
    input  logic [DekatronPkg::InsnWidth-1:0] progData,
    output logic [IpDigits*DekatronPkg::DigitWidth-1:0] ipAddress,
    output logic [ApDigits*DekatronPkg::DigitWidth-1:0] apAddress,
    output logic [DataDigits*DekatronPkg::DigitWidth-1:0] data,
    output logic [LoopDigits*DekatronPkg::DigitWidth-1:0] loopCount,
    output DekatronPkg::dpcState state,
    output logic cout
);
    localparam int IpWidth = IpDigits * DekatronPkg::DigitWidth;
    localparam int ApWidth = ApDigits * DekatronPkg::DigitWidth;
    localparam int DataWidth = DataDigits * DekatronPkg::DigitWidth;

    logic [DekatronPkg::InsnWidth-1:0] progMem [1 << IpWidth];
    logic [DataWidth-1:0] dataMem [1 << ApWidth];
    logic [(1 << ApWidth)-1:0] cellValid;
    logic [DataWidth-1:0] cellValue;

    DekatronPkg::insnOpcode memInsn;
    DekatronPkg::insnOpcode insn;
    DekatronPkg::dpcState nextState;
    logic stepMode;
    logic haltRequest;
    logic endInsn;
    logic ipInc;
    logic ipDec;
    logic apInc;
    logic apDec;
    logic dataInc;
    logic dataDec;
    logic dataLoad;
    logic dataZero;
    logic cellWrite;
    logic loopClear;
    logic loopInc;
    logic loopDec;
    logic loopZero;

    assign memInsn = DekatronPkg::insnOpcode'(progMem[ipAddress]);
    assign cellValue = cellValid[apAddress] ? dataMem[apAddress] : '0; // untouched cells read 0.

    always_comb begin
        {ipInc, ipDec, apInc, apDec, dataInc, dataDec, dataLoad} = '0;
        {cellWrite, loopClear, loopInc, loopDec, endInsn} = '0;
        nextState = state;
        case (state)
            DekatronPkg::stHalted: if (run || step) nextState = DekatronPkg::stFetch;
            DekatronPkg::stFetch: nextState = DekatronPkg::stExecute;
            DekatronPkg::stExecute: begin
                ipInc = 1'b1;
                endInsn = 1'b1;
                case (insn)
                    DekatronPkg::opInc: dataInc = 1'b1;
                    DekatronPkg::opDec: dataDec = 1'b1;
                    DekatronPkg::opNext, DekatronPkg::opPrev: begin
                        cellWrite = 1'b1;
                        apInc = (insn == DekatronPkg::opNext);
                        apDec = (insn == DekatronPkg::opPrev);
                        endInsn = 1'b0;
                        nextState = DekatronPkg::stLoadCell;
                    end
                    DekatronPkg::opLoopStart: if (dataZero) begin
                        loopClear = 1'b1;
                        endInsn = 1'b0;
                        nextState = DekatronPkg::stSeekForward;
                    end
                    DekatronPkg::opLoopEnd: if (!dataZero) begin
                        ipInc = 1'b0;
                        ipDec = 1'b1;
                        loopClear = 1'b1;
                        endInsn = 1'b0;
                        nextState = DekatronPkg::stSeekBackward;
                    end
                    DekatronPkg::opHalt: begin
                        ipInc = 1'b0; // IP stays on the halt.
                        endInsn = 1'b0;
                        nextState = DekatronPkg::stHalted;
                    end
                    default: ;
                endcase
            end
            DekatronPkg::stLoadCell: begin
                dataLoad = 1'b1;
                endInsn = 1'b1;
            end
            DekatronPkg::stSeekForward: begin
                ipInc = 1'b1;
                if (memInsn == DekatronPkg::opLoopStart) loopInc = 1'b1;
                else if (memInsn == DekatronPkg::opLoopEnd) begin
                    if (loopZero) endInsn = 1'b1;
                    else loopDec = 1'b1;
                end
            end
            DekatronPkg::stSeekBackward: begin
                if (memInsn == DekatronPkg::opLoopStart && loopZero) begin
                    ipInc = 1'b1; // land just past the matching bracket.
                    endInsn = 1'b1;
                end else begin
                    ipDec = 1'b1;
                    loopInc = (memInsn == DekatronPkg::opLoopEnd);
                    loopDec = (memInsn == DekatronPkg::opLoopStart);
                end
            end
            default: nextState = DekatronPkg::stHalted;
        endcase
        if (endInsn) begin
            nextState = (stepMode || haltRequest || halt) ? DekatronPkg::stHalted
                                                         : DekatronPkg::stFetch;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= DekatronPkg::stHalted;
            stepMode <= 1'b0;
            haltRequest <= 1'b0;
            cellValid <= '0;
        end else begin
            state <= nextState;
            if (state == DekatronPkg::stHalted && (run || step)) stepMode <= !run;
            haltRequest <= (nextState != DekatronPkg::stHalted)
                && (haltRequest || (halt && state != DekatronPkg::stHalted));
            if (cellWrite) cellValid[apAddress] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (progWrite) progMem[progAddr] <= progData;
        if (cellWrite) dataMem[apAddress] <= data;
        if (state == DekatronPkg::stFetch) insn <= memInsn;
    end

    DekatronCounter #(.Digits(IpDigits)) ipCounter (
        .Clk(Clk), .reset(reset), .clear(1'b0), .increment(ipInc), .decrement(ipDec),
        .load(1'b0), .loadValue('0), .value(ipAddress), .isZero(), .wrap()
    );

    DekatronCounter #(.Digits(ApDigits)) apCounter (
        .Clk(Clk), .reset(reset), .clear(1'b0), .increment(apInc), .decrement(apDec),
        .load(1'b0), .loadValue('0), .value(apAddress), .isZero(), .wrap()
    );

    DekatronCounter #(.Digits(DataDigits)) dataCounter (
        .Clk(Clk), .reset(reset), .clear(1'b0), .increment(dataInc), .decrement(dataDec),
        .load(dataLoad), .loadValue(cellValue), .value(data), .isZero(dataZero), .wrap(cout)
    );

    DekatronCounter #(.Digits(LoopDigits)) loopCounter (
        .Clk(Clk), .reset(reset), .clear(loopClear), .increment(loopInc), .decrement(loopDec),
        .load(1'b0), .loadValue('0), .value(loopCount), .isZero(loopZero), .wrap()
    );

endmodule

//--- src/DekatronPkg.sv
package DekatronPkg;

    localparam int DigitWidth = 4; // one BCD digit per tube.
    localparam int InsnWidth = 3;

    typedef enum logic [InsnWidth-1:0] {
        opNop       = 3'd0,
        opInc       = 3'd1,
        opDec       = 3'd2,
        opNext      = 3'd3,
        opPrev      = 3'd4,
        opLoopStart = 3'd5,
        opLoopEnd   = 3'd6,
        opHalt      = 3'd7
    } insnOpcode;

    typedef enum logic [2:0] {
        stHalted       = 3'd0,
        stFetch        = 3'd1,
        stExecute      = 3'd2,
        stLoadCell     = 3'd3, // reload data counter after a pointer move.
        stSeekForward  = 3'd4,
        stSeekBackward = 3'd5
    } dpcState;

endpackage

//--- src/Emulator.sv
`timescale 1ns/1ps

module Emulator #(
    parameter int IpDigits = 2,
    parameter int ApDigits = 2,
    parameter int DataDigits = 3,
    parameter int LoopDigits = 2,
    parameter int ScanDivisor = 4
) (
    input  logic Clk,
    input  logic reset,
    input  logic [PanelPkg::KeyRows-1:0] keyRows,
    output logic [2:0] keyColumn,
    output logic Cout,
    output DekatronPkg::dpcState DPC_currentState,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr
);
    logic [IpDigits*DekatronPkg::DigitWidth-1:0] ipAddress;
    logic [ApDigits*DekatronPkg::DigitWidth-1:0] apAddress;
    logic [DataDigits*DekatronPkg::DigitWidth-1:0] data;
    logic [LoopDigits*DekatronPkg::DigitWidth-1:0] loopCount;
    logic [IpDigits*DekatronPkg::DigitWidth-1:0] progAddr;
    logic [DekatronPkg::InsnWidth-1:0] progData;
    logic [PanelPkg::KeyCount-1:0] keysCurrentState;
    logic progWrite;
    logic keyRunPulse;
    logic keyHaltPulse;
    logic keyStepPulse;
    logic hostRun;
    logic hostHalt;
    logic hostStep;

    DekatronPC #(
        .IpDigits(IpDigits), .ApDigits(ApDigits), .DataDigits(DataDigits), .LoopDigits(LoopDigits)
    ) dekatronPC (
        .Clk(Clk), .reset(reset),
        .run(keyRunPulse || hostRun), // panel and host share the controls.
        .halt(keyHaltPulse || hostHalt),
        .step(keyStepPulse || hostStep),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .ipAddress(ipAddress), .apAddress(apAddress), .data(data), .loopCount(loopCount),
        .state(DPC_currentState), .cout(Cout)
    );

    KeyboardScanner #(.ScanDivisor(ScanDivisor)) keyboardScanner (
        .Clk(Clk), .reset(reset), .keyRows(keyRows), .keyColumn(keyColumn),
        .keysCurrentState(keysCurrentState), .keyRunPulse(keyRunPulse),
        .keyHaltPulse(keyHaltPulse), .keyStepPulse(keyStepPulse)
    );

    ApbRegisterBlock #(
        .IpDigits(IpDigits), .ApDigits(ApDigits), .DataDigits(DataDigits), .LoopDigits(LoopDigits)
    ) apbRegisterBlock (
        .Clk(Clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .state(DPC_currentState), .ipAddress(ipAddress), .apAddress(apAddress), .data(data),
        .loopCount(loopCount), .keysCurrentState(keysCurrentState),
        .hostRun(hostRun), .hostHalt(hostHalt), .hostStep(hostStep),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData)
    );

endmodule

//--- src/KeyboardScanner.sv
`timescale 1ns/1ps

module KeyboardScanner #(
    parameter int ScanDivisor = 4
) (
    input  logic Clk,
    input  logic reset,
    input  logic [PanelPkg::KeyRows-1:0] keyRows,
    output logic [2:0] keyColumn,
    output logic [PanelPkg::KeyCount-1:0] keysCurrentState,
    output logic keyRunPulse,
    output logic keyHaltPulse,
    output logic keyStepPulse
);
    localparam int PrescaleWidth = $clog2(ScanDivisor + 1);

    logic [PrescaleWidth-1:0] prescale;
    logic [2:0] lastKeys;
    logic scanTick;

    assign scanTick = (prescale == PrescaleWidth'(ScanDivisor - 1));

    always_ff @(posedge Clk) begin
        if (reset) begin
            prescale <= '0;
            keyColumn <= '0;
            keysCurrentState <= '0;
            lastKeys <= '0;
            keyRunPulse <= 1'b0;
            keyHaltPulse <= 1'b0;
            keyStepPulse <= 1'b0;
        end else begin
            prescale <= scanTick ? '0 : prescale + 1'b1;
            if (scanTick) begin
                keysCurrentState[keyColumn*PanelPkg::KeyRows +: PanelPkg::KeyRows] <= keyRows;
                keyColumn <= (keyColumn == 3'(PanelPkg::KeyColumns - 1)) ? '0
                                                                         : keyColumn + 1'b1;
            end
            lastKeys <= {keysCurrentState[PanelPkg::KeyStep],
                         keysCurrentState[PanelPkg::KeyHalt],
                         keysCurrentState[PanelPkg::KeyRun]};
            keyRunPulse <= keysCurrentState[PanelPkg::KeyRun] && !lastKeys[0]; // rising edge.
            keyHaltPulse <= keysCurrentState[PanelPkg::KeyHalt] && !lastKeys[1];
            keyStepPulse <= keysCurrentState[PanelPkg::KeyStep] && !lastKeys[2];
        end
    end

endmodule

//--- src/PanelPkg.sv
package PanelPkg;

    localparam int KeyColumns = 8;
    localparam int KeyRows = 5;
    localparam int KeyCount = KeyColumns * KeyRows;

    localparam int KeyRun = 0; // index is column * KeyRows + row.
    localparam int KeyHalt = 1;
    localparam int KeyStep = 2;

    localparam logic [11:0] RegControl = 12'h000;
    localparam logic [11:0] RegStatus = 12'h004;
    localparam logic [11:0] RegIp = 12'h008;
    localparam logic [11:0] RegAp = 12'h00C;
    localparam logic [11:0] RegData = 12'h010;
    localparam logic [11:0] RegLoop = 12'h014;
    localparam logic [11:0] RegKeysLow = 12'h018;
    localparam logic [11:0] RegKeysHigh = 12'h01C;
    localparam logic [11:0] ProgramBase = 12'h400;

endpackage
